/* project.f */
hw/tlp_tx_pkg.sv
hw/tx_rr_arbiter.sv
hw/tx_skid_buffer.sv
hw/tx_arb_ctrl.sv
hw/tlp_tx_mux.sv
testbench/tx_checker.sv
testbench/tb_tlp_tx_mux.sv

/* testbench/tb_tlp_tx_mux.sv */
// Testbench top for the TX merge path
// Clock, reset, LFSR stimulus, source drivers, test phases and watchdog

`timescale 1ns/1ps

module tb_tlp_tx_mux;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 3;
    localparam int          PHASE_CYCLES = 2000;
    localparam int          NUM_PHASES   = 4;
    localparam int          DRAIN_LIMIT  = 200;
    localparam int          STARVE_LOG2  = 4;
    localparam logic [31:0] LFSR_SEED    = 32'd29;
    // Twice the nominal length of all phases
    localparam int          WATCHDOG_NS  = NUM_PHASES * PHASE_CYCLES * CLK_PERIOD * 2;

    logic                  clk;
    logic                  reset_n;
    tlp_tx_pkg::t_tlp_beat mmio_beat, rd_beat, wr_beat;
    logic                  mmio_valid, rd_valid, wr_valid;
    logic                  mmio_ready, rd_ready, wr_ready;
    logic                  rd_tag_available;
    tlp_tx_pkg::t_tlp_beat tx_beat;
    logic                  tx_valid;
    logic                  tx_ready;

    // Source state indexed 0 for MMIO, 1 for read and 2 for write
    tlp_tx_pkg::t_tlp_beat cur_beat [3];
    logic                  cur_valid [3];
    logic                  pkt_poison [3];
    int                    beats_left [3];
    int                    tag_count [3];

    // Phase knobs
    logic [31:0] lfsr_state;
    int          offer_rate;
    int          ready_mode;
    logic        tags_low;
    logic        poison_on;
    logic        draining;
    string       phase_name;
    int          tb_errors;
    int          drain_cycles;

    tlp_tx_mux #(.WR_STARVE_LOG2(STARVE_LOG2)) i_dut
    (
        .clk(clk), .reset_n(reset_n),
        .mmio_beat(mmio_beat), .mmio_valid(mmio_valid), .mmio_ready(mmio_ready),
        .rd_beat(rd_beat), .rd_valid(rd_valid), .rd_ready(rd_ready),
        .wr_beat(wr_beat), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .rd_tag_available(rd_tag_available),
        .tx_beat(tx_beat), .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

    tx_checker #(.WR_STARVE_LOG2(STARVE_LOG2)) i_checker
    (
        .clk(clk), .reset_n(reset_n),
        .mmio_beat(mmio_beat), .mmio_valid(mmio_valid), .mmio_ready(mmio_ready),
        .rd_beat(rd_beat), .rd_valid(rd_valid), .rd_ready(rd_ready),
        .wr_beat(wr_beat), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .rd_tag_available(rd_tag_available),
        .tx_beat(tx_beat), .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================
    // Random source
    // ==================================================

    // 32-bit Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per returned bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[62:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // ==================================================
    // Source drivers
    // ==================================================

    task automatic set_phase(input int p);
        offer_rate = (p == 0) ? 2 : 3;
        ready_mode = (p == 1) ? 1 : ((p == 3) ? 2 : 0);
        tags_low   = (p == 2);
        poison_on  = (p == 3);
        case (p)
            0:       phase_name = "open traffic";
            1:       phase_name = "random back-pressure";
            2:       phase_name = "no read tags";
            default: phase_name = "poisoned packets";
        endcase
    endtask

    // Header beat of a new packet
    task automatic start_packet(input int src);
        tlp_tx_pkg::t_tlp_beat b;
        logic [63:0]           r;
        logic                  wide;
        int                    pkt_len;
        b    = '0;
        wide = take_bits(1) != 0;
        case (src)
            0:
            begin
                pkt_len = 1 + int'(take_bits(1));
                b.fmt   = wide ? tlp_tx_pkg::CPLD : tlp_tx_pkg::CPL;
            end
            1:
            begin
                pkt_len = 1;
                b.fmt   = wide ? tlp_tx_pkg::MEM_RD64 : tlp_tx_pkg::MEM_RD32;
            end
            default:
            begin
                pkt_len = 1 + int'(take_bits(2));
                b.fmt   = wide ? tlp_tx_pkg::MEM_WR64 : tlp_tx_pkg::MEM_WR32;
            end
        endcase
        r = take_bits(30);
        b.addr[31:0] = {r[29:0], 2'b00};
        // 64-bit forms always carry a nonzero upper half
        if (wide)
        begin
            r = take_bits(31);
            b.addr[63:32] = {r[30:0], 1'b1};
        end
        b.len_dw = (src == 1) ? 10'd1 + 10'(take_bits(7)) : 10'(pkt_len * 2);
        b.tag    = tag_count[src][7:0];
        tag_count[src]++;
        pkt_poison[src] = poison_on && (take_bits(2) == 0);
        b.sop    = 1'b1;
        b.eop    = (pkt_len == 1);
        b.poison = pkt_poison[src];
        b.data   = take_bits(64);
        cur_beat[src]   = b;
        cur_valid[src]  = 1'b1;
        beats_left[src] = pkt_len - 1;
    endtask

    // Payload beat that follows in the same packet
    task automatic next_beat(input int src);
        beats_left[src]--;
        cur_beat[src].sop  = 1'b0;
        cur_beat[src].eop  = (beats_left[src] == 0);
        cur_beat[src].data = take_bits(64);
        cur_valid[src]     = 1'b1;
    endtask

    // Called on each rising edge while readies still show this cycle's handshake
    task automatic step_sources();
        logic [2:0] ready_now;
        ready_now = {wr_ready, rd_ready, mmio_ready};
        for (int s = 0; s < 3; s++)
        begin
            if (cur_valid[s] && ready_now[s])
            begin
                cur_valid[s] = 1'b0;
            end
            if (!cur_valid[s])
            begin
                if (beats_left[s] > 0)
                begin
                    if (draining || take_bits(2) < offer_rate)
                    begin
                        next_beat(s);
                    end
                end
                else if (!draining && take_bits(2) < offer_rate)
                begin
                    start_packet(s);
                end
            end
        end
        mmio_beat  <= cur_beat[0];
        mmio_valid <= cur_valid[0];
        rd_beat    <= cur_beat[1];
        rd_valid   <= cur_valid[1];
        wr_beat    <= cur_beat[2];
        wr_valid   <= cur_valid[2];
        rd_tag_available <= draining || !tags_low;
        if (draining || ready_mode == 0)
        begin
            tx_ready <= 1'b1;
        end
        else
        begin
            tx_ready <= (ready_mode == 1) ? take_bits(1) != 0 : take_bits(2) != 0;
        end
    endtask

    function automatic logic all_idle();
        return !cur_valid[0] && !cur_valid[1] && !cur_valid[2] &&
               beats_left[0] == 0 && beats_left[2] == 0 &&
               i_checker.expect_q.size() == 0 && !tx_valid;
    endfunction

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        lfsr_state = LFSR_SEED;
        tb_errors  = 0;
        draining   = 1'b0;
        set_phase(0);
        for (int s = 0; s < 3; s++)
        begin
            cur_beat[s]   = '0;
            cur_valid[s]  = 1'b0;
            pkt_poison[s] = 1'b0;
            beats_left[s] = 0;
            tag_count[s]  = 0;
        end
        reset_n          = 1'b1;
        mmio_beat        = '0;
        rd_beat          = '0;
        wr_beat          = '0;
        mmio_valid       = 1'b0;
        rd_valid         = 1'b0;
        wr_valid         = 1'b0;
        rd_tag_available = 1'b1;
        tx_ready         = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b0;

        for (int p = 0; p < NUM_PHASES; p++)
        begin
            set_phase(p);
            repeat (PHASE_CYCLES)
            begin
                @(posedge clk);
                step_sources();
            end
            $display("Phase %0d (%s) finished: %0d beats accepted, %0d sent, %0d errors so far",
                     p + 1, phase_name, i_checker.accepted_count, i_checker.sent_count,
                     i_checker.error_count);
        end

        // Let open packets finish and the buffer empty
        draining     = 1'b1;
        drain_cycles = 0;
        while (!all_idle() && drain_cycles < DRAIN_LIMIT)
        begin
            @(posedge clk);
            step_sources();
            drain_cycles++;
        end
        @(negedge clk);
        if (!all_idle())
        begin
            $display("Drain failed: traffic still pending after %0d cycles", drain_cycles);
            tb_errors++;
        end
        i_checker.check_drained();
        $display("Drain finished after %0d cycles", drain_cycles);

        $display("Totals: %0d cycles, %0d accepted, %0d poisoned, %0d sent, %0d errors",
                 i_checker.cycle_count, i_checker.accepted_count, i_checker.poison_count,
                 i_checker.sent_count, i_checker.error_count + tb_errors);
        if (i_checker.error_count + tb_errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run timed out", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* testbench/tx_checker.sv */
// Checker for the TX merge path
// Models round-robin pointer, packet lock, write starvation and output order

`timescale 1ns/1ps

module tx_checker
#(
    parameter int WR_STARVE_LOG2 = 4
)
(
    input logic                  clk,
    input logic                  reset_n,
    input tlp_tx_pkg::t_tlp_beat mmio_beat,
    input logic                  mmio_valid,
    input logic                  mmio_ready,
    input tlp_tx_pkg::t_tlp_beat rd_beat,
    input logic                  rd_valid,
    input logic                  rd_ready,
    input tlp_tx_pkg::t_tlp_beat wr_beat,
    input logic                  wr_valid,
    input logic                  wr_ready,
    input logic                  rd_tag_available,
    input tlp_tx_pkg::t_tlp_beat tx_beat,
    input logic                  tx_valid,
    input logic                  tx_ready
);

    localparam int STARVE_LIMIT = 1 << WR_STARVE_LOG2;

    // Accepted beats still owed on tx_beat, oldest first
    tlp_tx_pkg::t_tlp_beat expect_q [$];

    // Arbitration model
    tlp_tx_pkg::t_arb_state lock_state = tlp_tx_pkg::ARB_NONE;
    int   last_grant = 2;
    int   starve_ctr = 0;
    logic force_wr   = 1'b0;

    // Output of the previous cycle, for the hold rule
    tlp_tx_pkg::t_tlp_beat prev_beat;
    logic prev_valid = 1'b0;
    logic prev_ready = 1'b0;
    logic was_reset  = 1'b0;

    int error_count    = 0;
    int cycle_count    = 0;
    int accepted_count = 0;
    int poison_count   = 0;
    int sent_count     = 0;

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s expected %0b, got %0b",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t ns: %s", $time, what);
        error_count++;
    endtask

    // First requester after the last winner, wrapping round
    function automatic logic [2:0] pick_after(input logic [2:0] req, input int last);
        logic [2:0] gnt;
        int         idx;
        gnt = 3'b000;
        for (int step = 1; step <= 3; step++)
        begin
            idx = (last + step) % 3;
            if (gnt == 3'b000 && req[idx])
            begin
                gnt[idx] = 1'b1;
            end
        end
        return gnt;
    endfunction

    // Pointer, lock and starvation state after this cycle's grant
    task automatic advance_model(input logic [2:0] gnt, input logic mmio_eop, input logic wr_eop);
        if (lock_state == tlp_tx_pkg::ARB_NONE && gnt != 3'b000)
        begin
            last_grant = gnt[0] ? 0 : (gnt[1] ? 1 : 2);
        end
        if (gnt[0] && !mmio_eop)
        begin
            lock_state = tlp_tx_pkg::ARB_LOCK_MMIO;
        end
        else if (gnt[2] && !wr_eop)
        begin
            lock_state = tlp_tx_pkg::ARB_LOCK_WR;
        end
        else if (gnt != 3'b000)
        begin
            lock_state = tlp_tx_pkg::ARB_NONE;
        end
        if (gnt[2])
        begin
            starve_ctr = 0;
            force_wr   = 1'b0;
        end
        else if (starve_ctr == STARVE_LIMIT)
        begin
            force_wr = 1'b1;
        end
        else
        begin
            starve_ctr++;
        end
    endtask

    // ==================================================
    // Per-cycle checks, sampled mid-cycle
    // ==================================================

    always @(negedge clk)
    begin
        logic [2:0] valid_vec;
        logic [2:0] ready_vec;
        logic [2:0] req_vec;
        logic [2:0] exp_gnt;
        logic       buf_ready;
        if (reset_n)
        begin
            if (was_reset && (tx_valid || mmio_ready || rd_ready || wr_ready))
            begin
                report_failure("tx_valid or a source ready was high after reset");
            end
            expect_q.delete();
            lock_state = tlp_tx_pkg::ARB_NONE;
            last_grant = 2;
            starve_ctr = 0;
            force_wr   = 1'b0;
            prev_valid = 1'b0;
            prev_ready = 1'b0;
            was_reset  = 1'b1;
        end
        else if (was_reset)
        begin
            cycle_count++;
            valid_vec = {wr_valid, rd_valid, mmio_valid};
            ready_vec = {wr_ready, rd_ready, mmio_ready};
            // Skid buffer takes a beat while it holds at most one
            buf_ready = expect_q.size() < 2;

            // Output stream
            compare_bit("tx_valid", expect_q.size() > 0, tx_valid);
            if (prev_valid && !prev_ready && tx_valid && tx_beat !== prev_beat)
            begin
                report_failure("tx_beat changed while tx_ready was low");
            end
            if (tx_valid && tx_beat.poison)
            begin
                report_failure("a poisoned beat reached tx_beat");
            end
            if (tx_valid && expect_q.size() > 0 && tx_beat !== expect_q[0])
            begin
                $display("Mismatch at %0t ns: tx_beat expected %h, got %h",
                         $time, expect_q[0], tx_beat);
                error_count++;
            end

            // Expected grant
            req_vec = {wr_valid && (rd_tag_available || force_wr), rd_valid, mmio_valid};
            exp_gnt = 3'b000;
            case (lock_state)
                tlp_tx_pkg::ARB_LOCK_MMIO: exp_gnt[0] = mmio_valid && buf_ready;
                tlp_tx_pkg::ARB_LOCK_WR:   exp_gnt[2] = wr_valid && buf_ready;
                default:
                begin
                    if (buf_ready)
                    begin
                        exp_gnt = pick_after(req_vec, last_grant);
                    end
                end
            endcase
            compare_bit("mmio_ready", exp_gnt[0], mmio_ready);
            compare_bit("rd_ready", exp_gnt[1], rd_ready);
            compare_bit("wr_ready", exp_gnt[2], wr_ready);
            if ((ready_vec & ~valid_vec) != 3'b000)
            begin
                report_failure("a source ready was high without its valid");
            end
            if ((ready_vec & (ready_vec - 3'd1)) != 3'b000)
            begin
                report_failure("more than one source ready in the same cycle");
            end
            if (!buf_ready && ready_vec != 3'b000)
            begin
                report_failure("a source ready rose while two beats were buffered");
            end

            // Beats leaving, then beats taken in
            if (tx_valid && tx_ready && expect_q.size() > 0)
            begin
                void'(expect_q.pop_front());
                sent_count++;
            end
            for (int s = 0; s < 3; s++)
            begin
                tlp_tx_pkg::t_tlp_beat b;
                b = (s == 0) ? mmio_beat : ((s == 1) ? rd_beat : wr_beat);
                if (valid_vec[s] && ready_vec[s])
                begin
                    accepted_count++;
                    if (b.poison)
                    begin
                        poison_count++;
                    end
                    else
                    begin
                        expect_q.push_back(b);
                    end
                end
            end

            advance_model(exp_gnt, mmio_beat.eop, wr_beat.eop);
            prev_beat  = tx_beat;
            prev_valid = tx_valid;
            prev_ready = tx_ready;
        end
    end

    // Every kept beat must have left by the end
    task automatic check_drained();
        if (expect_q.size() != 0)
        begin
            report_failure($sformatf("%0d accepted beats never left on tx_beat",
                                     expect_q.size()));
        end
    endtask

endmodule

/* hw/tlp_tx_mux.sv */
// Top level of the TX merge path
// Arbitration control feeding the two-entry output skid buffer

`timescale 1ns/1ps

module tlp_tx_mux
#(
    // Cycles without a write grant before writes are forced, as a power of 2
    parameter int WR_STARVE_LOG2 = 4
)
(
    input  logic                  clk,
    input  logic                  reset_n,

    // MMIO completions
    input  tlp_tx_pkg::t_tlp_beat mmio_beat,
    input  logic                  mmio_valid,
    output logic                  mmio_ready,

    // Read requests, always single beat
    input  tlp_tx_pkg::t_tlp_beat rd_beat,
    input  logic                  rd_valid,
    output logic                  rd_ready,

    // Write requests
    input  tlp_tx_pkg::t_tlp_beat wr_beat,
    input  logic                  wr_valid,
    output logic                  wr_ready,

    // Read side still has completion tags
    input  logic                  rd_tag_available,

    // Merged stream towards the host
    output tlp_tx_pkg::t_tlp_beat tx_beat,
    output logic                  tx_valid,
    input  logic                  tx_ready
);

    // Arbitrated stream between control and skid buffer
    tlp_tx_pkg::t_tlp_beat merged_beat;
    logic                  merged_valid;
    logic                  merged_ready;

    // Round-robin merge with packet lock and write throttle
    tx_arb_ctrl
    #(
        .WR_STARVE_LOG2(WR_STARVE_LOG2)
    )
    i_arb_ctrl
    (
        .clk             (clk),
        .reset_n         (reset_n),
        .mmio_beat       (mmio_beat),
        .mmio_valid      (mmio_valid),
        .mmio_ready      (mmio_ready),
        .rd_beat         (rd_beat),
        .rd_valid        (rd_valid),
        .rd_ready        (rd_ready),
        .wr_beat         (wr_beat),
        .wr_valid        (wr_valid),
        .wr_ready        (wr_ready),
        .rd_tag_available(rd_tag_available),
        .merged_beat     (merged_beat),
        .merged_valid    (merged_valid),
        .merged_ready    (merged_ready)
    );

    // Registered output stage, poisoned beats vanish here
    tx_skid_buffer i_skid_buffer
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .in_beat  (merged_beat),
        .in_valid (merged_valid),
        .in_ready (merged_ready),
        .out_beat (tx_beat),
        .out_valid(tx_valid),
        .out_ready(tx_ready)
    );

endmodule

/* hw/tx_arb_ctrl.sv */
// TX arbitration control for MMIO, read and write producers
// Packet lock FSM, write starvation throttle, grant qualification and beat mux

`timescale 1ns/1ps

module tx_arb_ctrl
#(
    parameter int WR_STARVE_LOG2 = 4
)
(
    input  logic                  clk,
    input  logic                  reset_n,

    input  tlp_tx_pkg::t_tlp_beat mmio_beat,
    input  logic                  mmio_valid,
    output logic                  mmio_ready,

    input  tlp_tx_pkg::t_tlp_beat rd_beat,
    input  logic                  rd_valid,
    output logic                  rd_ready,

    input  tlp_tx_pkg::t_tlp_beat wr_beat,
    input  logic                  wr_valid,
    output logic                  wr_ready,

    input  logic                  rd_tag_available,

    output tlp_tx_pkg::t_tlp_beat merged_beat,
    output logic                  merged_valid,
    input  logic                  merged_ready
);

    tlp_tx_pkg::t_arb_state arb_state;
    tlp_tx_pkg::t_src_grant arb_req;
    tlp_tx_pkg::t_src_grant arb_grant;

    logic arb_ena;
    logic grant_mmio, grant_rd, grant_wr;

    // Cycles since the last write grant, top bit marks the limit
    logic [WR_STARVE_LOG2:0] non_wr_ctr;
    logic                    force_allow_wr;

    // ==================================================
    // Requests and round-robin
    // ==================================================

    assign arb_req.mmio = mmio_valid;
    assign arb_req.rd   = rd_valid;
    // Writes wait while reads are out of tags, unless starved too long
    assign arb_req.wr   = wr_valid && (rd_tag_available || force_allow_wr);

    // Fresh arbitration only between packets
    assign arb_ena = merged_ready && (arb_state == tlp_tx_pkg::ARB_NONE);

    tx_rr_arbiter i_rr_arbiter
    (
        .clk    (clk),
        .reset_n(reset_n),
        .ena    (arb_ena),
        .request(arb_req),
        .grant  (arb_grant)
    );

    // Locked producer keeps the stream until its eop beat
    assign grant_mmio = arb_grant.mmio ||
                        ((arb_state == tlp_tx_pkg::ARB_LOCK_MMIO) && merged_ready && mmio_valid);
    assign grant_rd   = arb_grant.rd;
    assign grant_wr   = arb_grant.wr ||
                        ((arb_state == tlp_tx_pkg::ARB_LOCK_WR) && merged_ready && wr_valid);

    // ==================================================
    // Readies and beat mux
    // ==================================================

    assign mmio_ready   = grant_mmio;
    assign rd_ready     = grant_rd;
    assign wr_ready     = grant_wr;
    assign merged_valid = grant_mmio || grant_rd || grant_wr;

    always_comb
    begin
        if (grant_mmio)
        begin
            merged_beat = mmio_beat;
        end
        else if (grant_rd)
        begin
            merged_beat = rd_beat;
        end
        else
        begin
            merged_beat = wr_beat;
        end
    end

    // ==================================================
    // Packet lock FSM
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            arb_state <= tlp_tx_pkg::ARB_NONE;
        end
        else if (grant_mmio && !mmio_beat.eop)
        begin
            arb_state <= tlp_tx_pkg::ARB_LOCK_MMIO;
        end
        else if (grant_wr && !wr_beat.eop)
        begin
            arb_state <= tlp_tx_pkg::ARB_LOCK_WR;
        end
        else if (merged_valid)
        begin
            // eop beat or single-beat packet went out
            arb_state <= tlp_tx_pkg::ARB_NONE;
        end
    end

    // Starvation counter saturates at the limit
    always_ff @(posedge clk)
    begin
        if (reset_n || grant_wr)
        begin
            non_wr_ctr     <= '0;
            force_allow_wr <= 1'b0;
        end
        else
        begin
            if (!non_wr_ctr[WR_STARVE_LOG2])
            begin
                non_wr_ctr <= non_wr_ctr + 1'b1;
            end
            if (non_wr_ctr[WR_STARVE_LOG2])
            begin
                force_allow_wr <= 1'b1;
            end
        end
    end

    // Lock path and arbiter together must still pick one winner
    a_single_winner : assert property (@(posedge clk) disable iff (reset_n)
        $onehot0({grant_mmio, grant_rd, grant_wr}))
        else $error("tx_arb_ctrl: multiple arbitration winners");

endmodule

/* hw/tx_skid_buffer.sv */
// Two-entry output skid buffer for the merged TX stream
// Drops poisoned beats, checks 32/64-bit address encoding on headers

`timescale 1ns/1ps

module tx_skid_buffer
(
    input  logic                  clk,
    input  logic                  reset_n,

    input  tlp_tx_pkg::t_tlp_beat in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,

    output tlp_tx_pkg::t_tlp_beat out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    // Main drives the output, spare catches the beat in flight
    tlp_tx_pkg::t_tlp_beat main_beat;
    tlp_tx_pkg::t_tlp_beat spare_beat;
    logic                  main_valid;
    logic                  spare_valid;

    logic accept;
    logic keep;
    logic main_free;

    // Spare only fills behind main, so a free spare means one entry or less
    assign in_ready  = !spare_valid;
    assign accept    = in_valid && in_ready;
    // Poisoned beats are taken in and thrown away
    assign keep      = accept && !in_beat.poison;
    assign main_free = !main_valid || out_ready;

    assign out_beat  = main_beat;
    assign out_valid = main_valid;

    // ==================================================
    // Entry control
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end
        else if (main_free)
        begin
            // Spare moves up first to keep order
            main_valid  <= spare_valid || keep;
            spare_valid <= 1'b0;
        end
        else if (keep)
        begin
            spare_valid <= 1'b1;
        end
    end

    // Payload path
    always_ff @(posedge clk)
    begin
        if (main_free)
        begin
            main_beat <= spare_valid ? spare_beat : in_beat;
        end
        if (keep && !main_free)
        begin
            spare_beat <= in_beat;
        end
    end

    // ==================================================
    // Address format checks
    // ==================================================

    // 64-bit opcodes need a nonzero upper address
    a_addr64_upper : assert property (@(posedge clk) disable iff (reset_n)
        (keep && in_beat.sop &&
         (in_beat.fmt == tlp_tx_pkg::MEM_RD64 || in_beat.fmt == tlp_tx_pkg::MEM_WR64))
        |-> (in_beat.addr[63:32] != 32'b0))
        else $error("tx_skid_buffer: 64-bit request with 32-bit address");

    // 32-bit opcodes must keep the upper half clear
    a_addr32_upper : assert property (@(posedge clk) disable iff (reset_n)
        (keep && in_beat.sop &&
         (in_beat.fmt == tlp_tx_pkg::MEM_RD32 || in_beat.fmt == tlp_tx_pkg::MEM_WR32))
        |-> (in_beat.addr[63:32] == 32'b0))
        else $error("tx_skid_buffer: 32-bit request with 64-bit address");

endmodule

/* hw/tx_rr_arbiter.sv */
// Round-robin arbiter over the TX producers
// Rotating priority pointer, grant only while enabled

`timescale 1ns/1ps

module tx_rr_arbiter
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   ena,
    input  tlp_tx_pkg::t_src_grant request,
    output tlp_tx_pkg::t_src_grant grant
);

    localparam int IDX_W = $clog2(tlp_tx_pkg::NUM_TX_SRC);

    // Index ordered views of request and grant
    logic [tlp_tx_pkg::NUM_TX_SRC-1:0] req_vec;
    logic [tlp_tx_pkg::NUM_TX_SRC-1:0] gnt_vec;

    // Last winner and the winner chosen this cycle
    logic [IDX_W-1:0] last_idx;
    logic [IDX_W-1:0] gnt_idx;
    logic [IDX_W-1:0] cand;
    logic             found;

    assign req_vec = {request.wr, request.rd, request.mmio};

    // Search starts one past the previous winner and wraps
    always_comb
    begin
        gnt_vec = '0;
        gnt_idx = last_idx;
        found   = 1'b0;
        cand    = '0;
        if (ena)
        begin
            for (int i = 1; i <= tlp_tx_pkg::NUM_TX_SRC; i++)
            begin
                cand = IDX_W'((int'(last_idx) + i) % tlp_tx_pkg::NUM_TX_SRC);
                if (!found && req_vec[cand])
                begin
                    found         = 1'b1;
                    gnt_idx       = cand;
                    gnt_vec[cand] = 1'b1;
                end
            end
        end
    end

    assign grant.mmio = gnt_vec[0];
    assign grant.rd   = gnt_vec[1];
    assign grant.wr   = gnt_vec[2];

    // Pointer moves only on a real grant
    // Reset to the last index so MMIO wins first
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            last_idx <= IDX_W'(tlp_tx_pkg::NUM_TX_SRC - 1);
        end
        else if (found)
        begin
            last_idx <= gnt_idx;
        end
    end

    // Grant is one-hot or zero, and present whenever enabled with a request
    a_grant_onehot : assert property (@(posedge clk) disable iff (reset_n)
        $onehot0({grant.mmio, grant.rd, grant.wr}) &&
        (({grant.mmio, grant.rd, grant.wr} != 3'b000) == (ena && req_vec != '0)))
        else $error("tx_rr_arbiter: grant not one-hot or missing");

endmodule

/* hw/tlp_tx_pkg.sv */
// Shared types and constants for the TLP transmit merge path
// Beat struct, opcode and lock-state enums, grant vector struct

package tlp_tx_pkg;

    // ==================================================
    // Width constants
    // ==================================================

    // Payload bits carried by one beat
    localparam int TLP_DATA_W = 64;
    // DWORD length field of a header
    localparam int TLP_LEN_W  = 10;
    // Producers feeding the merge, 0 is MMIO, 1 is read, 2 is write
    localparam int NUM_TX_SRC = 3;

    // ==================================================
    // Opcodes and states
    // ==================================================

    // Header format and type, reduced to what this path emits
    typedef enum logic [2:0] {
        MEM_RD32 = 3'd0,
        MEM_RD64 = 3'd1,
        MEM_WR32 = 3'd2,
        MEM_WR64 = 3'd3,
        CPL      = 3'd4,
        CPLD     = 3'd5
    } t_tlp_fmt;

    // Packet lock held by the TX arbitration
    typedef enum logic [1:0] {
        ARB_NONE,
        ARB_LOCK_MMIO,
        ARB_LOCK_WR
    } t_arb_state;

    // ==================================================
    // Structs
    // ==================================================

    // One beat of a TLP
    // Header fields only count when sop is set
    typedef struct packed {
        t_tlp_fmt              fmt;
        logic [63:0]           addr;
        logic [TLP_LEN_W-1:0]  len_dw;
        logic [7:0]            tag;
        logic                  sop;
        logic                  eop;
        logic                  poison;
        logic [TLP_DATA_W-1:0] data;
    } t_tlp_beat;

    // One request or grant bit per producer
    typedef struct packed {
        logic mmio;
        logic rd;
        logic wr;
    } t_src_grant;

endpackage
